// ==== flist.f ====
+incdir+bench
common/baser_rx_pkg.sv
rtl/baser_block_decoder.sv
rtl/eth_crc32_check.sv
frame/rx_frame_ctrl.sv
rtl/rx_baser_32.sv
bench/tb_rx_baser.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list the targets"

test:
	verilator --binary --timing --top-module tb_rx_baser -f flist.f -o sim_rx_baser
	./obj_dir/sim_rx_baser

clean:
	rm -rf obj_dir

// ==== bench/frame_encode.svh ====
// frame to 64b/66b block encoder, idle block and reference crc-32
`ifndef FRAME_ENCODE_SVH
`define FRAME_ENCODE_SVH

localparam logic [7:0] TERM_TYPES [8] = '{
    baser_rx_pkg::BLOCK_TYPE_TERM_0, baser_rx_pkg::BLOCK_TYPE_TERM_1,
    baser_rx_pkg::BLOCK_TYPE_TERM_2, baser_rx_pkg::BLOCK_TYPE_TERM_3,
    baser_rx_pkg::BLOCK_TYPE_TERM_4, baser_rx_pkg::BLOCK_TYPE_TERM_5,
    baser_rx_pkg::BLOCK_TYPE_TERM_6, baser_rx_pkg::BLOCK_TYPE_TERM_7
};

// bytewise, lsb first, complemented result goes out low byte first
function automatic logic [31:0] ref_crc(input logic [7:0] fb[$]);
    logic [31:0] poly;
    logic [31:0] c;
    poly = {<<{baser_rx_pkg::CRC_POLY}};
    c = '1;
    foreach (fb[i]) begin
        c = c ^ {24'd0, fb[i]};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ poly) : (c >> 1);
        end
    end
    return ~c;
endfunction

function automatic logic [65:0] idle_block();
    return {baser_rx_pkg::SYNC_CTRL, 56'd0, baser_rx_pkg::BLOCK_TYPE_CTRL};
endfunction

// line lanes from sl on: start, six preamble bytes, sfd, frame bytes, terminate
function automatic void encode_blocks(input logic [7:0] fb[$], input int sl, input bit bad_pre,
        input int abort_blk, output logic [65:0] blk[$]);
    logic [7:0] line[$];
    logic [63:0] d;
    logic [1:0]  hdr;
    int          t_pos;
    int          nblk;
    t_pos = sl + 8 + fb.size();
    nblk = t_pos / 8 + 1;
    blk = {};
    for (int p = 0; p < 8 * nblk; p++) begin
        line.push_back(8'h00);
    end
    for (int p = 1; p < 7; p++) begin
        line[sl + p] = baser_rx_pkg::ETH_PRE;
    end
    line[sl + 7] = baser_rx_pkg::ETH_SFD;
    if (bad_pre) begin
        line[sl + 2] = line[sl + 2] ^ 8'h01;
    end
    foreach (fb[i]) begin
        line[sl + 8 + i] = fb[i];
    end
    for (int k = 0; k < nblk; k++) begin
        hdr = baser_rx_pkg::SYNC_CTRL;
        d = '0;
        if (k == abort_blk) begin
            d[7:0] = baser_rx_pkg::BLOCK_TYPE_CTRL;
        end else if (k == 0) begin
            d[7:0] = sl == 0 ? baser_rx_pkg::BLOCK_TYPE_START_0 : baser_rx_pkg::BLOCK_TYPE_START_4;
            for (int b = sl + 1; b < 8; b++) begin
                d[8*b +: 8] = line[b];
            end
        end else if (k == nblk - 1) begin
            // data lanes ahead of the terminate sit from byte 1 up
            d[7:0] = TERM_TYPES[t_pos % 8];
            for (int b = 0; b < t_pos % 8; b++) begin
                d[8*b + 8 +: 8] = line[8*k + b];
            end
        end else begin
            hdr = baser_rx_pkg::SYNC_DATA;
            for (int b = 0; b < 8; b++) begin
                d[8*b +: 8] = line[8*k + b];
            end
        end
        blk.push_back({hdr, d});
    end
endfunction

`endif

// ==== bench/tb_rx_baser.sv ====
// receiver testbench with clock, frame stimulus, reference model, compare process and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_rx_baser;

    `include "frame_encode.svh"

    localparam int          CLK_PERIOD = 4;
    localparam int          NUM_FRAMES = 24;
    localparam int          MAX_LEN = 200;
    localparam logic [15:0] STD_MAX_LEN = 16'd1518;

    logic                    clk;
    logic                    reset_crc;
    logic [31:0]             encoded_rx_data;
    baser_rx_pkg::sync_hdr_t encoded_rx_hdr;
    logic                    encoded_rx_hdr_valid;
    logic [15:0]             cfg_rx_max_pkt_len;
    logic                    cfg_rx_enable;
    baser_rx_pkg::axis_rx_t  m_axis_rx;
    baser_rx_pkg::rx_stat_t  rx_stat;

    baser_rx_pkg::axis_rx_t  exp_words[$];
    baser_rx_pkg::rx_stat_t  exp_stats[$];
    logic [31:0]             rng_state;
    int                      frames_seen;

    rx_baser_32 dut (
        .clk                  (clk),
        .reset_crc            (reset_crc),
        .encoded_rx_data      (encoded_rx_data),
        .encoded_rx_hdr       (encoded_rx_hdr),
        .encoded_rx_hdr_valid (encoded_rx_hdr_valid),
        .cfg_rx_max_pkt_len   (cfg_rx_max_pkt_len),
        .cfg_rx_enable        (cfg_rx_enable),
        .m_axis_rx            (m_axis_rx),
        .rx_stat              (rx_stat)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // status the receiver should report for a frame of len delivered bytes
    function automatic baser_rx_pkg::rx_stat_t expect_stat(input int len, input bit fcs_bad,
            input bit pre_bad, input bit framing, input logic [15:0] max_len);
        baser_rx_pkg::rx_stat_t st;
        logic                   bad;
        st = '0;
        st.pkt_len = 16'(len);
        st.err_bad_fcs = fcs_bad;
        st.err_oversize = len > int'(max_len);
        st.err_framing = framing;
        st.err_preamble = pre_bad;
        bad = fcs_bad || st.err_oversize || framing;
        st.pkt_good = !bad;
        st.pkt_bad = bad;
        return st;
    endfunction

    task automatic expect_frame(input logic [7:0] fb[$], input int len,
            input baser_rx_pkg::rx_stat_t st);
        baser_rx_pkg::axis_rx_t w;
        for (int i = 0; i < len; i += 4) begin
            w = '0;
            w.tvalid = 1'b1;
            for (int k = 0; k < 4 && i + k < len; k++) begin
                w.tdata[8*k +: 8] = fb[i + k];
                w.tkeep[k] = 1'b1;
            end
            w.tlast = i + 4 >= len;
            w.tuser = w.tlast && st.pkt_bad;
            exp_words.push_back(w);
        end
        exp_stats.push_back(st);
    endtask

    task automatic check_stream(input baser_rx_pkg::axis_rx_t got,
            input baser_rx_pkg::axis_rx_t exp);
        if (got !== exp) begin
            fail_now($sformatf({"mismatch m_axis_rx frame %0d got tdata=%h tkeep=%h tlast=%h ",
                "tuser=%h expected tdata=%h tkeep=%h tlast=%h tuser=%h"}, frames_seen,
                got.tdata, got.tkeep, got.tlast, got.tuser,
                exp.tdata, exp.tkeep, exp.tlast, exp.tuser));
        end
    endtask

    task automatic check_stat(input baser_rx_pkg::rx_stat_t got,
            input baser_rx_pkg::rx_stat_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch rx_stat frame %0d got %h expected %h",
                frames_seen, got, exp));
        end
    endtask

    // one block is two words, the header rides on the first
    task automatic send_block(input logic [65:0] blk);
        encoded_rx_hdr = baser_rx_pkg::sync_hdr_t'(blk[65:64]);
        encoded_rx_hdr_valid = 1'b1;
        encoded_rx_data = blk[31:0];
        @(posedge clk);
        #0.5;
        encoded_rx_hdr_valid = 1'b0;
        encoded_rx_data = blk[63:32];
        @(posedge clk);
        #0.5;
    endtask

    // len counts destination address through fcs, abort_blk -1 for a whole frame
    task automatic run_frame(input int len, input int start_lane, input bit flip_fcs,
            input bit bad_pre, input int abort_blk, input bit enable,
            input logic [15:0] max_len);
        logic [7:0]             fb[$];
        logic [31:0]            fcs;
        logic [65:0]            blk[$];
        int                     delivered;
        baser_rx_pkg::rx_stat_t st;
        for (int i = 0; i < len - 4; i++) begin
            fb.push_back(8'(xorshift32()));
        end
        fcs = ref_crc(fb);
        for (int k = 0; k < 4; k++) begin
            fb.push_back(fcs[8*k +: 8]);
        end
        if (flip_fcs) begin
            fb[len - 2] = fb[len - 2] ^ 8'h10;
        end
        encode_blocks(fb, start_lane, bad_pre, abort_blk, blk);
        cfg_rx_max_pkt_len = max_len;
        cfg_rx_enable = enable;
        if (enable) begin
            delivered = abort_blk > 0 ? 8 * abort_blk - start_lane - 8 : len;
            st = expect_stat(delivered, flip_fcs, bad_pre, abort_blk > 0, max_len);
            expect_frame(fb, delivered, st);
        end
        foreach (blk[k]) begin
            send_block(blk[k]);
        end
        for (int k = 0; k < 3; k++) begin
            send_block(idle_block());
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (m_axis_rx.tvalid && exp_words.size() == 0) begin
                fail_now("output word arrived while no frame was expected");
            end else if (rx_stat != '0 && !(m_axis_rx.tvalid && m_axis_rx.tlast)) begin
                fail_now("status pulse outside the last word of a frame");
            end else if (m_axis_rx.tvalid) begin
                check_stream(m_axis_rx, exp_words.pop_front());
                if (m_axis_rx.tlast) begin
                    check_stat(rx_stat, exp_stats.pop_front());
                    frames_seen++;
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * NUM_FRAMES * (MAX_LEN / 4 + 20));
        fail_now("timeout, not every expected frame came out");
    end

    initial begin
        int s;
        int lane;
        int len;
        clk = 1'b0;
        rng_state = 32'd56;
        frames_seen = 0;
        reset_crc = 1'b1;
        encoded_rx_data = '0;
        encoded_rx_hdr = baser_rx_pkg::SYNC_CTRL;
        encoded_rx_hdr_valid = 1'b0;
        cfg_rx_max_pkt_len = STD_MAX_LEN;
        cfg_rx_enable = 1'b1;
        repeat (3) @(posedge clk);
        #0.5;
        reset_crc = 1'b0;
        for (int k = 0; k < 4; k++) begin
            send_block(idle_block());
        end

        // good frames over both start lanes and every terminate lane
        for (int i = 0; i < 16; i++) begin
            s = (i % 2) * 4;
            lane = i / 2;
            len = 64 + 8 * int'(xorshift32() % 17) + (lane - s + 8) % 8;
            run_frame(len, s, 1'b0, 1'b0, -1, 1'b1, STD_MAX_LEN);
        end

        run_frame(80, 0, 1'b1, 1'b0, -1, 1'b1, STD_MAX_LEN);
        run_frame(101, 4, 1'b0, 1'b0, -1, 1'b1, 16'd100);
        run_frame(100, 0, 1'b0, 1'b0, -1, 1'b1, 16'd100);
        run_frame(120, 4, 1'b0, 1'b0, -1, 1'b1, 16'd100);
        run_frame(90, 4, 1'b0, 1'b1, -1, 1'b1, STD_MAX_LEN);
        // idle block in place of the fourth block
        run_frame(96, 0, 1'b0, 1'b0, 3, 1'b1, STD_MAX_LEN);
        run_frame(72, 4, 1'b0, 1'b0, -1, 1'b0, STD_MAX_LEN);
        run_frame(68, 0, 1'b0, 1'b0, -1, 1'b1, STD_MAX_LEN);

        while (exp_words.size() != 0 || exp_stats.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rx_baser_32.sv ====
// 10GBASE-R 32-bit receive top level with block decoder, crc checker and frame controller
`timescale 1ns/10ps
`default_nettype none

module rx_baser_32 (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,

    // encoded input, header valid marks the first word of a block
    input  wire logic [31:0]               encoded_rx_data,
    input  wire baser_rx_pkg::sync_hdr_t   encoded_rx_hdr,
    input  wire logic                      encoded_rx_hdr_valid,

    input  wire logic [15:0]               cfg_rx_max_pkt_len,
    input  wire logic                      cfg_rx_enable,

    output wire baser_rx_pkg::axis_rx_t    m_axis_rx,
    output wire baser_rx_pkg::rx_stat_t    rx_stat
);

    wire baser_rx_pkg::dec_word_t dec_word;
    wire logic                    crc_clear;
    wire logic [3:0]              crc_match;

    baser_block_decoder u_decoder (
        .clk                  (clk),
        .reset_crc            (reset_crc),
        .encoded_rx_data      (encoded_rx_data),
        .encoded_rx_hdr       (encoded_rx_hdr),
        .encoded_rx_hdr_valid (encoded_rx_hdr_valid),
        .dec_word             (dec_word)
    );

    // crc runs on the decoder output, two words ahead of the frame fsm
    eth_crc32_check u_crc (
        .clk       (clk),
        .reset_crc (reset_crc),
        .data      (dec_word.data),
        .crc_clear (crc_clear),
        .crc_match (crc_match)
    );

    rx_frame_ctrl u_frame (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .dec_word           (dec_word),
        .crc_match          (crc_match),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .cfg_rx_enable      (cfg_rx_enable),
        .crc_clear          (crc_clear),
        .m_axis_rx          (m_axis_rx),
        .rx_stat            (rx_stat)
    );

endmodule

`default_nettype wire

// ==== frame/rx_frame_ctrl.sv ====
// receive frame fsm with delay line, length limit, output stream and status record
`timescale 1ns/10ps
`default_nettype none

module rx_frame_ctrl (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire baser_rx_pkg::dec_word_t   dec_word,
    input  wire logic [3:0]                crc_match,
    input  wire logic [15:0]               cfg_rx_max_pkt_len,
    input  wire logic                      cfg_rx_enable,
    output logic                           crc_clear,
    output baser_rx_pkg::axis_rx_t         m_axis_rx,
    output baser_rx_pkg::rx_stat_t         rx_stat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_LAST
    } state_t;

    state_t                  state_reg, state_next;

    // d2 is the word on its way out, d1 is the one behind it
    baser_rx_pkg::dec_word_t dec_d1, dec_d2;
    // lines up with d2
    logic [3:0]              crc_match_d;

    logic                    pre_ok_reg, pre_ok_next;
    logic                    oversize_reg, oversize_next;
    logic [15:0]             frame_len_reg, frame_len_next;
    // full words still allowed, then bytes allowed in the last one
    logic [13:0]             lim_cyc_reg, lim_cyc_next;
    logic [1:0]              lim_last_reg, lim_last_next;

    logic                    frame_end;
    logic                    end_fcs_ok;
    logic                    end_framing;

    baser_rx_pkg::axis_rx_t  axis_next;
    baser_rx_pkg::rx_stat_t  stat_next;

    function automatic logic [15:0] len_add(input logic [15:0] len, input logic [2:0] inc);
        logic [16:0] sum;
        sum = {1'b0, len} + {14'd0, inc};
        return sum[16] ? 16'hffff : sum[15:0];
    endfunction

    // crc restarts whenever no frame is in progress
    assign crc_clear = state_next == ST_IDLE;

    always_comb begin
        state_next = state_reg;
        pre_ok_next = pre_ok_reg;
        oversize_next = oversize_reg;
        frame_len_next = frame_len_reg;
        lim_cyc_next = lim_cyc_reg;
        lim_last_next = lim_last_reg;

        frame_end = 1'b0;
        end_fcs_ok = 1'b1;
        end_framing = 1'b0;

        axis_next = '0;
        axis_next.tdata = dec_d2.data;
        stat_next = '0;

        case (state_reg)
            ST_IDLE: begin
                oversize_next = 1'b0;
                {lim_cyc_next, lim_last_next} = cfg_rx_max_pkt_len;
                // byte 0 holds the block type or a control byte
                pre_ok_next = dec_d2.data[31:8] == {3{baser_rx_pkg::ETH_PRE}};
                if (dec_d2.start && cfg_rx_enable) begin
                    if (dec_d2.framing_error) begin
                        stat_next.err_framing = 1'b1;
                    end else begin
                        state_next = ST_PREAMBLE;
                    end
                end
            end
            ST_PREAMBLE: begin
                frame_len_next = 16'd0;
                pre_ok_next = pre_ok_reg &&
                    dec_d2.data == {baser_rx_pkg::ETH_SFD, {3{baser_rx_pkg::ETH_PRE}}};
                if (dec_d2.framing_error) begin
                    stat_next.err_framing = 1'b1;
                    state_next = ST_IDLE;
                end else begin
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                axis_next.tkeep = 4'hf;
                axis_next.tvalid = 1'b1;
                frame_len_next = len_add(frame_len_reg, 3'd4);
                if (lim_cyc_reg == 14'd0) begin
                    oversize_next = 1'b1;
                end else begin
                    lim_cyc_next = lim_cyc_reg - 14'd1;
                end

                // look one word ahead so d2 can carry tlast
                if (dec_d1.framing_error) begin
                    frame_end = 1'b1;
                    end_framing = 1'b1;
                    state_next = ST_IDLE;
                end else if (dec_d1.term_present && dec_d1.term_first) begin
                    frame_end = 1'b1;
                    end_fcs_ok = crc_match_d[3];
                    state_next = ST_IDLE;
                end else if (dec_d1.term_present) begin
                    state_next = ST_LAST;
                end
            end
            ST_LAST: begin
                axis_next.tkeep = ~(4'hf << dec_d2.term_lane);
                axis_next.tvalid = 1'b1;
                frame_len_next = len_add(frame_len_reg, {1'b0, dec_d2.term_lane});
                if (lim_cyc_reg == 14'd0 && dec_d2.term_lane > lim_last_reg) begin
                    oversize_next = 1'b1;
                end
                frame_end = 1'b1;
                end_fcs_ok = crc_match_d[dec_d2.term_lane - 2'd1];
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase

        if (frame_end) begin
            axis_next.tlast = 1'b1;
            axis_next.tuser = end_framing || !end_fcs_ok || oversize_next;
            stat_next.pkt_len = frame_len_next;
            stat_next.pkt_good = !axis_next.tuser;
            stat_next.pkt_bad = axis_next.tuser;
            stat_next.err_bad_fcs = !end_fcs_ok;
            stat_next.err_oversize = oversize_next;
            stat_next.err_framing = end_framing;
            // reported only, a bad preamble does not fail the frame
            stat_next.err_preamble = !pre_ok_reg;
        end
    end

    always_ff @(posedge clk) begin
        dec_d1 <= dec_word;
        dec_d2 <= dec_d1;
        crc_match_d <= crc_match;

        state_reg <= state_next;
        pre_ok_reg <= pre_ok_next;
        oversize_reg <= oversize_next;
        frame_len_reg <= frame_len_next;
        lim_cyc_reg <= lim_cyc_next;
        lim_last_reg <= lim_last_next;

        m_axis_rx <= axis_next;
        rx_stat <= stat_next;

        if (reset_crc) begin
            state_reg <= ST_IDLE;
            dec_d1.start <= 1'b0;
            dec_d2.start <= 1'b0;
            dec_d1.term_present <= 1'b0;
            dec_d2.term_present <= 1'b0;
            m_axis_rx.tvalid <= 1'b0;
            rx_stat <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eth_crc32_check.sv ====
// ethernet crc-32 word update and registered residue match per final lane count
`timescale 1ns/10ps
`default_nettype none

module eth_crc32_check (
    input  wire logic        clk,
    input  wire logic        reset_crc,
    input  wire logic [31:0] data,
    input  wire logic        crc_clear,
    output logic [3:0]       crc_match
);

    function automatic logic [31:0] reflect(input logic [31:0] value);
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            result[i] = value[31-i];
        end
        return result;
    endfunction

    localparam logic [31:0] POLY_REFL = reflect(baser_rx_pkg::CRC_POLY);

    // byte 0 goes in first, lsb first within each byte
    function automatic logic [31:0] crc_word(input logic [31:0] state, input logic [31:0] word);
        logic [31:0] s;
        s = state ^ word;
        for (int i = 0; i < 32; i++) begin
            s = s[0] ? ((s >> 1) ^ POLY_REFL) : (s >> 1);
        end
        return s;
    endfunction

    logic [31:0] crc_state;
    logic [31:0] crc_next;

    assign crc_next = crc_word(crc_state, data);

    always_ff @(posedge clk) begin
        if (crc_clear) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end

        // match bits cover the word just absorbed
        for (int k = 0; k < 4; k++) begin
            crc_match[k] <= crc_next == baser_rx_pkg::CRC_RESIDUE[k];
        end

        if (reset_crc) begin
            crc_state <= '1;
            crc_match <= 4'd0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/baser_block_decoder.sv ====
// block decoder with input registers, type decode, terminate alignment, start and framing flags
`timescale 1ns/10ps
`default_nettype none

module baser_block_decoder (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire logic [31:0]               encoded_rx_data,
    input  wire baser_rx_pkg::sync_hdr_t   encoded_rx_hdr,
    input  wire logic                      encoded_rx_hdr_valid,
    output baser_rx_pkg::dec_word_t        dec_word
);

    logic [31:0]             in_data_reg;
    baser_rx_pkg::sync_hdr_t in_hdr_reg;
    logic                    in_hdr_valid_reg;

    // frame currently open on the line
    logic                    frame_open;

    // flags for the second word of the current block
    logic                    start_alt;
    logic                    term_alt;
    logic                    term_first_alt;
    logic [1:0]              term_lane_alt;

    logic [3:0]              blk_nib;

    function automatic logic [3:0] type_nib(input logic [7:0] bt);
        return bt[7:4];
    endfunction

    // keep the bytes ahead of the terminate, they sit from byte 1 up
    function automatic logic [31:0] pad_term(input logic [31:0] word, input logic [1:0] lanes);
        case (lanes)
            2'd1: return {24'd0, word[15:8]};
            2'd2: return {16'd0, word[23:8]};
            2'd3: return {8'd0, word[31:8]};
            default: return word;
        endcase
    endfunction

    assign blk_nib = in_data_reg[7:4];

    always_ff @(posedge clk) begin
        in_data_reg <= encoded_rx_data;
        in_hdr_reg <= encoded_rx_hdr;
        in_hdr_valid_reg <= encoded_rx_hdr_valid;

        dec_word.data <= in_data_reg;
        dec_word.start <= start_alt;
        dec_word.term_present <= term_alt;
        dec_word.term_first <= term_first_alt;
        dec_word.term_lane <= term_lane_alt;

        start_alt <= 1'b0;
        term_alt <= 1'b0;
        term_first_alt <= 1'b0;
        term_lane_alt <= 2'd0;

        if (in_hdr_valid_reg) begin
            if (in_hdr_reg != baser_rx_pkg::SYNC_CTRL) begin
                dec_word.framing_error <= !frame_open;
            end else begin
                case (blk_nib)
                    type_nib(baser_rx_pkg::BLOCK_TYPE_START_0): begin
                        dec_word.start <= 1'b1;
                        dec_word.framing_error <= frame_open;
                        frame_open <= 1'b1;
                    end
                    type_nib(baser_rx_pkg::BLOCK_TYPE_START_4),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_OS_START): begin
                        start_alt <= 1'b1;
                        dec_word.framing_error <= frame_open;
                        frame_open <= 1'b1;
                    end
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_0),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_1),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_2),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_3): begin
                        dec_word.data <= pad_term(in_data_reg, blk_nib[1:0]);
                        dec_word.term_present <= 1'b1;
                        dec_word.term_first <= blk_nib[1:0] == 2'd0;
                        dec_word.term_lane <= blk_nib[1:0];
                        dec_word.framing_error <= 1'b0;
                        frame_open <= 1'b0;
                    end
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_4),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_5),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_6),
                    type_nib(baser_rx_pkg::BLOCK_TYPE_TERM_7): begin
                        // D3 comes from lane 4, the low byte of the next word
                        dec_word.data <= {encoded_rx_data[7:0], in_data_reg[31:8]};
                        term_alt <= 1'b1;
                        term_first_alt <= blk_nib[1:0] == 2'd0;
                        term_lane_alt <= blk_nib[1:0];
                        dec_word.framing_error <= 1'b0;
                        frame_open <= 1'b0;
                    end
                    default: begin
                        // idle, ordered sets and unknown types
                        dec_word.framing_error <= frame_open;
                        frame_open <= 1'b0;
                    end
                endcase
            end
        end else begin
            // term_lane_alt is zero unless a late terminate is pending
            dec_word.data <= pad_term(in_data_reg, term_lane_alt);
        end

        if (reset_crc) begin
            in_hdr_valid_reg <= 1'b0;
            frame_open <= 1'b0;
            start_alt <= 1'b0;
            term_alt <= 1'b0;
            term_first_alt <= 1'b0;
            term_lane_alt <= 2'd0;
            dec_word.start <= 1'b0;
            dec_word.term_present <= 1'b0;
            dec_word.term_first <= 1'b0;
            dec_word.term_lane <= 2'd0;
            dec_word.framing_error <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== common/baser_rx_pkg.sv ====
// sync headers, block types, ethernet and crc constants, decoder word, stream and status structs
`default_nettype none

package baser_rx_pkg;

    // 64b/66b sync header, first word of each block only
    typedef enum logic [1:0] {
        SYNC_DATA = 2'b10,
        SYNC_CTRL = 2'b01
    } sync_hdr_t;

    // block type field, byte 0 of a control block
    typedef enum logic [7:0] {
        BLOCK_TYPE_CTRL     = 8'h1e,
        BLOCK_TYPE_OS_4     = 8'h2d,
        BLOCK_TYPE_START_4  = 8'h33,
        BLOCK_TYPE_OS_START = 8'h66,
        BLOCK_TYPE_OS_04    = 8'h55,
        BLOCK_TYPE_START_0  = 8'h78,
        BLOCK_TYPE_OS_0     = 8'h4b,
        BLOCK_TYPE_TERM_0   = 8'h87,
        BLOCK_TYPE_TERM_1   = 8'h99,
        BLOCK_TYPE_TERM_2   = 8'haa,
        BLOCK_TYPE_TERM_3   = 8'hb4,
        BLOCK_TYPE_TERM_4   = 8'hcc,
        BLOCK_TYPE_TERM_5   = 8'hd2,
        BLOCK_TYPE_TERM_6   = 8'he1,
        BLOCK_TYPE_TERM_7   = 8'hff
    } block_type_t;

    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

    // normal form, the checker reflects it
    localparam logic [31:0] CRC_POLY = 32'h04c11db7;

    // state after a good FCS, zero padded to the word
    // index is the byte count of the final word minus one
    localparam logic [3:0][31:0] CRC_RESIDUE = {
        ~32'h2144df1c,
        ~32'hc622f71d,
        ~32'hb1c2a1a3,
        ~32'h9d6cdf7e
    };

    // one aligned word out of the block decoder
    typedef struct packed {
        logic [31:0] data;
        logic        start;
        logic        term_present;
        // terminate in lane 0, no frame bytes in this word
        logic        term_first;
        logic [1:0]  term_lane;
        logic        framing_error;
    } dec_word_t;

    typedef struct packed {
        logic [31:0] tdata;
        logic [3:0]  tkeep;
        logic        tvalid;
        logic        tlast;
        logic        tuser;
    } axis_rx_t;

    // single-cycle per-frame report
    typedef struct packed {
        logic [15:0] pkt_len;
        logic        pkt_good;
        logic        pkt_bad;
        logic        err_bad_fcs;
        logic        err_oversize;
        logic        err_framing;
        logic        err_preamble;
    } rx_stat_t;

endpackage

`default_nettype wire
